// File: aluOpDecode.sv
`default_nettype none
`timescale 1ns/10ps

module aluOpDecode
    import decodePkg::*;
(
    input  instrWordU instr,
    output ctrlWordT  ctrl,
    output logic      claim
);

    logic [5:0] funct6;
    logic       isWord;
    logic       illegalOp;

    assign funct6 = instr.r.funct7[6:1];
    assign isWord = (instr.r.opcode == opOpW);

    always_comb begin
        ctrl = '0;
        claim = 1'b0;
        illegalOp = 1'b0;
        case (instr.r.opcode)
            opLui: begin
                claim = 1'b1;
                ctrl.immSel = immU;
                ctrl.bSel = 1'b1;
                ctrl.aluOp = aluB;
            end
            opAuipc: begin
                claim = 1'b1;
                ctrl.immSel = immU;
                ctrl.aSel = 1'b1;
                ctrl.bSel = 1'b1;
                ctrl.aluOp = aluAdd;
            end
            opOpImm: begin
                claim = 1'b1;
                ctrl.immSel = immI;
                ctrl.bSel = 1'b1;
                ctrl.rs1En = 1'b1;
                case (instr.i.funct3)
                    f3AddSub: ctrl.aluOp = aluAdd;
                    f3Sll: begin
                        ctrl.aluOp = aluSll;
                        illegalOp = (funct6 != f6Logic);
                    end
                    f3Slt: begin
                        ctrl.aluOp = aluB;
                        ctrl.sltEn = 1'b1;
                    end
                    f3Sltu: begin
                        ctrl.aluOp = aluB;
                        ctrl.sltEn = 1'b1;
                        ctrl.brUnsigned = 1'b1;
                    end
                    f3Xor: ctrl.aluOp = aluXor;
                    f3SrlSra: begin
                        if (funct6 == f6Logic)
                            ctrl.aluOp = aluSrl;
                        else if (funct6 == f6Arith)
                            ctrl.aluOp = aluSra;
                        else
                            illegalOp = 1'b1;
                    end
                    f3Or: ctrl.aluOp = aluOr;
                    f3And: ctrl.aluOp = aluAnd;
                endcase
            end
            opOpImmW: begin
                claim = 1'b1;
                ctrl.immSel = immI;
                ctrl.bSel = 1'b1;
                ctrl.rs1En = 1'b1;
                case (instr.i.funct3)
                    f3AddSub: ctrl.aluOp = aluAddw;
                    f3Sll: begin
                        ctrl.aluOp = aluSllw;
                        illegalOp = (instr.r.funct7 != f7Base);
                    end
                    f3SrlSra: begin
                        if (instr.r.funct7 == f7Base)
                            ctrl.aluOp = aluSrlw;
                        else if (instr.r.funct7 == f7Alt)
                            ctrl.aluOp = aluSraw;
                        else
                            illegalOp = 1'b1;
                    end
                    default: illegalOp = 1'b1;
                endcase
            end
            opOp, opOpW: begin
                claim = 1'b1;
                ctrl.rs1En = 1'b1;
                ctrl.rs2En = 1'b1;
                case (instr.r.funct7)
                    f7Base: begin
                        case (instr.r.funct3)
                            f3AddSub: ctrl.aluOp = isWord ? aluAddw : aluAdd;
                            f3Sll: ctrl.aluOp = isWord ? aluSllw : aluSll;
                            f3SrlSra: ctrl.aluOp = isWord ? aluSrlw : aluSrl;
                            f3Slt, f3Sltu: begin
                                ctrl.aluOp = aluB;
                                ctrl.sltEn = 1'b1;
                                ctrl.brUnsigned = instr.r.funct3[0];
                                illegalOp = isWord;
                            end
                            f3Xor: ctrl.aluOp = aluXor;
                            f3Or: ctrl.aluOp = aluOr;
                            f3And: ctrl.aluOp = aluAnd;
                        endcase
                        // word forms only exist for add, sll and srl
                        if (isWord && instr.r.funct3[2] && instr.r.funct3 != f3SrlSra)
                            illegalOp = 1'b1;
                    end
                    f7Alt: begin
                        if (instr.r.funct3 == f3AddSub)
                            ctrl.aluOp = isWord ? aluSubw : aluSub;
                        else if (instr.r.funct3 == f3SrlSra)
                            ctrl.aluOp = isWord ? aluSraw : aluSra;
                        else
                            illegalOp = 1'b1;
                    end
                    f7MulDiv: begin
                        // div code is word, enable, rem, unsigned
                        if (instr.r.funct3 == f3Mul)
                            ctrl.mulOp = {isWord, 1'b1};
                        else if (instr.r.funct3[2])
                            ctrl.divOp = {isWord, 1'b1, instr.r.funct3[1:0]};
                        else
                            illegalOp = 1'b1;
                    end
                    default: illegalOp = 1'b1;
                endcase
            end
            default: claim = 1'b0;
        endcase
        if (claim) begin
            ctrl.regWrite = 1'b1;
            ctrl.wbSel = 1'b1;
            ctrl.rd = instr.r.rd;
        end
        ctrl.exc.illegal = illegalOp;
        ctrl.isSystem = illegalOp;
    end

endmodule

`default_nettype wire

// File: decodePkg.sv
`default_nettype none

package decodePkg;

    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011,
        opOpImmW = 7'b0011011,
        opOpW    = 7'b0111011,
        opSystem = 7'b1110011
    } opcodeE;

    // integer ALU funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Mul    = 3'b000;

    // load/store funct3, stores use the first four
    localparam logic [2:0] f3Byte   = 3'b000;
    localparam logic [2:0] f3Half   = 3'b001;
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3Dword  = 3'b011;
    localparam logic [2:0] f3ByteU  = 3'b100;
    localparam logic [2:0] f3HalfU  = 3'b101;
    localparam logic [2:0] f3WordU  = 3'b110;

    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [2:0] f3Blt    = 3'b100;
    localparam logic [2:0] f3Bge    = 3'b101;
    localparam logic [2:0] f3Bltu   = 3'b110;
    localparam logic [2:0] f3Bgeu   = 3'b111;

    localparam logic [2:0] f3Priv   = 3'b000;
    localparam logic [2:0] f3Csrrw  = 3'b001;
    localparam logic [2:0] f3Csrrs  = 3'b010;
    localparam logic [2:0] f3Csrrc  = 3'b011;
    localparam logic [2:0] f3Csrrwi = 3'b101;
    localparam logic [2:0] f3Csrrsi = 3'b110;
    localparam logic [2:0] f3Csrrci = 3'b111;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000;
    localparam logic [6:0] f7MulDiv = 7'b0000001;
    // rv64 immediate shifts keep bit 25 for shamt
    localparam logic [5:0] f6Logic  = 6'b000000;
    localparam logic [5:0] f6Arith  = 6'b010000;

    // instr[31:7] of the privileged forms
    localparam logic [24:0] f25Ecall = 25'h0000000;
    localparam logic [24:0] f25Mret  = 25'h0604000;

    typedef enum logic [2:0] {
        immNone, immI, immS, immB, immU, immJ, immCsr
    } immSelE;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluA, aluB,
        aluSll, aluSrl, aluSra, aluSllw, aluSrlw, aluSraw,
        aluAddw, aluSubw, aluNextPc, aluRevAnd, aluAndRev
    } aluOpE;

    typedef enum logic [1:0] {
        msize1, msize2, msize4, msize8
    } memSizeE;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrWordU;

    typedef struct packed {
        logic illegal;
        logic ecall;
        logic mret;
        logic misalign;
    } excFlagsT;

    typedef struct packed {
        immSelE      immSel;
        aluOpE       aluOp;
        logic        aSel;
        logic        bSel;
        logic        regWrite;
        logic        wbSel;
        logic [4:0]  rd;
        logic        rs1En;
        logic        rs2En;
        logic        memRead;
        logic        memWrite;
        memSizeE     memSize;
        logic        memUnsigned;
        logic        eqEn;
        logic        eqSel;
        logic        ltEn;
        logic        ltSel;
        logic        brUnsigned;
        logic        sltEn;
        logic        jalr;
        logic [1:0]  mulOp;
        logic [3:0]  divOp;
        logic [11:0] csrAddr;
        logic        csrRs1;
        logic        csrImm;
        logic        isSystem;
        excFlagsT    exc;
    } ctrlWordT;

endpackage

`default_nettype wire

// File: instrDecoder.sv
`default_nettype none
`timescale 1ns/10ps

module instrDecoder
    import decodePkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  instrWordU instrIn,
    input  logic      misalignIn,
    input  logic      inValid,
    output logic      inReady,
    output ctrlWordT  ctrlOut,
    output logic      outValid,
    input  logic      outReady
);

    ctrlWordT aluCtrl;
    ctrlWordT memCtrl;
    ctrlWordT sysCtrl;
    ctrlWordT ctrlNext;
    logic     aluClaim;
    logic     memClaim;
    logic     sysClaim;
    logic     accept;

    aluOpDecode uAluOpDecode (
        .instr (instrIn),
        .ctrl  (aluCtrl),
        .claim (aluClaim)
    );

    memBranchDecode uMemBranchDecode (
        .instr (instrIn),
        .ctrl  (memCtrl),
        .claim (memClaim)
    );

    systemDecode uSystemDecode (
        .instr (instrIn),
        .ctrl  (sysCtrl),
        .claim (sysClaim)
    );

    // claims are disjoint, each decoder owns its own opcodes
    always_comb begin
        ctrlNext = '0;
        if (aluClaim) begin
            ctrlNext = aluCtrl;
        end else if (memClaim) begin
            ctrlNext = memCtrl;
        end else if (sysClaim) begin
            ctrlNext = sysCtrl;
        end else begin
            ctrlNext.exc.illegal = 1'b1;
            ctrlNext.isSystem = 1'b1;
        end
        // zero word is a bubble
        if (instrIn == '0)
            ctrlNext = '0;
        if (misalignIn) begin
            ctrlNext.exc.misalign = 1'b1;
            ctrlNext.isSystem = 1'b1;
        end
    end

    assign inReady = !outValid || outReady;
    assign accept = inValid && inReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            outValid <= 1'b0;
        else if (accept)
            outValid <= 1'b1;
        else if (outReady)
            outValid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept)
            ctrlOut <= ctrlNext;
    end

endmodule

`default_nettype wire

// File: instrDecoderTb.sv
`default_nettype none
`timescale 1ns/10ps

module instrDecoderTb
    import decodePkg::*;
();

    localparam int numInstr = 600;
    localparam int cycleLimit = numInstr * 5;

    logic      clk;
    logic      rstN;
    instrWordU instrIn;
    logic      misalignIn;
    logic      inValid;
    logic      inReady;
    ctrlWordT  ctrlOut;
    logic      outValid;
    logic      outReady;

    integer    seed;
    ctrlWordT  expQ[$];
    ctrlWordT  expCtrl;
    int        inCount;
    int        outCount;
    int        cycles;
    logic      acceptedLast;

    instrDecoder DUT (
        .clk        (clk),
        .rstN       (rstN),
        .instrIn    (instrIn),
        .misalignIn (misalignIn),
        .inValid    (inValid),
        .inReady    (inReady),
        .ctrlOut    (ctrlOut),
        .outValid   (outValid),
        .outReady   (outReady)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // expected control word, straight from the RV64IM encoding rules
    function automatic ctrlWordT refDecode(input logic [31:0] w, input logic mis);
        ctrlWordT   c;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       wordOp;
        logic       bad;
        logic       linkRd;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        wordOp = (opc == 7'h3b);
        bad = 1'b0;
        linkRd = 1'b0;
        c = '0;
        case (opc)
            7'h37, 7'h17: begin
                c.immSel = immU;
                c.bSel = 1'b1;
                c.aSel = (opc == 7'h17);
                c.aluOp = (opc == 7'h17) ? aluAdd : aluB;
                linkRd = 1'b1;
            end
            7'h13: begin
                c.immSel = immI;
                c.bSel = 1'b1;
                c.rs1En = 1'b1;
                linkRd = 1'b1;
                case (f3)
                    3'd0: c.aluOp = aluAdd;
                    3'd1: begin
                        c.aluOp = aluSll;
                        bad = (f7[6:1] != 6'h00);
                    end
                    3'd2, 3'd3: begin
                        c.aluOp = aluB;
                        c.sltEn = 1'b1;
                        c.brUnsigned = f3[0];
                    end
                    3'd4: c.aluOp = aluXor;
                    3'd5: begin
                        if (f7[6:1] == 6'h00)
                            c.aluOp = aluSrl;
                        else if (f7[6:1] == 6'h10)
                            c.aluOp = aluSra;
                        else
                            bad = 1'b1;
                    end
                    3'd6: c.aluOp = aluOr;
                    default: c.aluOp = aluAnd;
                endcase
            end
            7'h1b: begin
                c.immSel = immI;
                c.bSel = 1'b1;
                c.rs1En = 1'b1;
                linkRd = 1'b1;
                if (f3 == 3'd0) begin
                    c.aluOp = aluAddw;
                end else if (f3 == 3'd1) begin
                    c.aluOp = aluSllw;
                    bad = (f7 != 7'h00);
                end else if (f3 == 3'd5 && f7 == 7'h00) begin
                    c.aluOp = aluSrlw;
                end else if (f3 == 3'd5 && f7 == 7'h20) begin
                    c.aluOp = aluSraw;
                end else begin
                    bad = 1'b1;
                end
            end
            7'h33, 7'h3b: begin
                c.rs1En = 1'b1;
                c.rs2En = 1'b1;
                linkRd = 1'b1;
                if (f7 == 7'h00) begin
                    case (f3)
                        3'd0: c.aluOp = wordOp ? aluAddw : aluAdd;
                        3'd1: c.aluOp = wordOp ? aluSllw : aluSll;
                        3'd2, 3'd3: begin
                            c.aluOp = aluB;
                            c.sltEn = 1'b1;
                            c.brUnsigned = f3[0];
                            bad = wordOp;
                        end
                        3'd4: begin
                            c.aluOp = aluXor;
                            bad = wordOp;
                        end
                        3'd5: c.aluOp = wordOp ? aluSrlw : aluSrl;
                        3'd6: begin
                            c.aluOp = aluOr;
                            bad = wordOp;
                        end
                        default: begin
                            c.aluOp = aluAnd;
                            bad = wordOp;
                        end
                    endcase
                end else if (f7 == 7'h20) begin
                    if (f3 == 3'd0)
                        c.aluOp = wordOp ? aluSubw : aluSub;
                    else if (f3 == 3'd5)
                        c.aluOp = wordOp ? aluSraw : aluSra;
                    else
                        bad = 1'b1;
                end else if (f7 == 7'h01) begin
                    if (f3 == 3'd0)
                        c.mulOp = {wordOp, 1'b1};
                    else if (f3[2])
                        c.divOp = {wordOp, 1'b1, f3[1:0]};
                    else
                        bad = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            7'h03: begin
                c.immSel = immI;
                c.bSel = 1'b1;
                c.rs1En = 1'b1;
                c.memRead = 1'b1;
                c.memUnsigned = f3[2];
                c.regWrite = 1'b1;
                c.rd = w[11:7];
                if (f3 == 3'd7)
                    bad = 1'b1;
                else
                    c.memSize = memSizeE'(f3[1:0]);
            end
            7'h23: begin
                c.immSel = immS;
                c.bSel = 1'b1;
                c.rs1En = 1'b1;
                c.rs2En = 1'b1;
                c.memWrite = 1'b1;
                if (f3[2])
                    bad = 1'b1;
                else
                    c.memSize = memSizeE'(f3[1:0]);
            end
            7'h63: begin
                c.immSel = immB;
                c.aSel = 1'b1;
                c.bSel = 1'b1;
                c.rs1En = 1'b1;
                c.rs2En = 1'b1;
                if (f3[2:1] == 2'b01) begin
                    bad = 1'b1;
                end else if (!f3[2]) begin
                    c.eqEn = 1'b1;
                    c.eqSel = !f3[0];
                end else begin
                    c.ltEn = 1'b1;
                    c.ltSel = !f3[0];
                    c.brUnsigned = f3[1];
                end
            end
            7'h6f, 7'h67: begin
                c.jalr = (opc == 7'h67);
                c.immSel = c.jalr ? immI : immJ;
                c.rs1En = c.jalr;
                c.aSel = 1'b1;
                c.aluOp = aluNextPc;
                linkRd = 1'b1;
            end
            7'h73: begin
                c.isSystem = 1'b1;
                c.csrAddr = w[31:20];
                if (f3 == 3'd0) begin
                    c.exc.ecall = (w[31:7] == 25'h0000000);
                    c.exc.mret = (w[31:7] == 25'h0604000);
                    bad = !(c.exc.ecall || c.exc.mret);
                end else if (f3 == 3'd4) begin
                    bad = 1'b1;
                end else begin
                    c.csrRs1 = !f3[2];
                    c.rs1En = !f3[2];
                    c.csrImm = f3[2];
                    c.bSel = f3[2];
                    c.immSel = f3[2] ? immCsr : immNone;
                    case (f3[1:0])
                        2'd1: c.aluOp = f3[2] ? aluB : aluA;
                        2'd2: c.aluOp = aluOr;
                        default: c.aluOp = f3[2] ? aluAndRev : aluRevAnd;
                    endcase
                    linkRd = 1'b1;
                end
            end
            default: bad = 1'b1;
        endcase
        if (linkRd) begin
            c.regWrite = 1'b1;
            c.wbSel = 1'b1;
            c.rd = w[11:7];
        end
        if (bad) begin
            c.exc.illegal = 1'b1;
            c.isSystem = 1'b1;
        end
        if (w == 32'h0)
            c = '0;
        if (mis) begin
            c.exc.misalign = 1'b1;
            c.isSystem = 1'b1;
        end
        return c;
    endfunction

    function automatic logic [6:0] pickOpcode(input logic [3:0] idx);
        case (idx)
            4'd0: return 7'h37;
            4'd1: return 7'h17;
            4'd2: return 7'h6f;
            4'd3: return 7'h67;
            4'd4: return 7'h63;
            4'd5: return 7'h03;
            4'd6: return 7'h23;
            4'd7: return 7'h13;
            4'd8: return 7'h33;
            4'd9: return 7'h1b;
            4'd10: return 7'h3b;
            4'd11: return 7'h73;
            // opcodes this core does not implement
            4'd12: return 7'h0f;
            4'd13: return 7'h2f;
            4'd14: return 7'h5b;
            default: return 7'h7f;
        endcase
    endfunction

    task automatic buildWord(output logic [31:0] w, output logic mis);
        logic [31:0] r;
        logic [31:0] f;
        r = $random(seed);
        f = $random(seed);
        case (r[3:0])
            4'd0: w = 32'h0;
            4'd1: w = f;
            4'd2: w = 32'h00000073;
            4'd3: w = 32'h30200073;
            default: begin
                w = f;
                w[6:0] = pickOpcode(r[7:4]);
                case (r[10:8])
                    3'd0, 3'd1: w[31:25] = 7'h00;
                    3'd2: w[31:25] = 7'h20;
                    3'd3: w[31:25] = 7'h01;
                    3'd4: w[31:25] = 7'h21;
                    default: w[31:25] = f[31:25];
                endcase
            end
        endcase
        mis = (r[15:12] == 4'd0);
    endtask

    // handshake values are stable here, DUT registers update after this
    always @(posedge clk) begin
        if (rstN) begin
            cycles++;
            if (cycles > cycleLimit) begin
                abortRun("timeout, decoder did not deliver all outputs in time");
            end else begin
                if (acceptedLast)
                    assert (outValid)
                        else abortRun("outValid did not rise one cycle after an accepted input");
                if (outValid && outReady) begin
                    assert (expQ.size() > 0)
                        else abortRun("output transfer with no accepted input pending");
                    expCtrl = expQ.pop_front();
                    assert (ctrlOut === expCtrl)
                        else abortRun($sformatf("Error: ctrlOut = %h, expected %h",
                            ctrlOut, expCtrl));
                    outCount++;
                end
                acceptedLast = inValid && inReady;
                if (inValid && inReady) begin
                    expQ.push_back(refDecode(instrIn, misalignIn));
                    inCount++;
                end
            end
        end
    end

    initial begin
        logic [31:0] w;
        logic        mis;
        logic        accepted;
        seed = 32'hc68fa5b2;
        rstN = 1'b1;
        instrIn = '0;
        misalignIn = 1'b0;
        inValid = 1'b0;
        outReady = 1'b0;
        inCount = 0;
        outCount = 0;
        cycles = 0;
        acceptedLast = 1'b0;
        #1;
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < numInstr; i++) begin
            // occasional idle cycle between words
            while (($random(seed) & 7) == 0) begin
                inValid = 1'b0;
                outReady = ($random(seed) & 3) != 0;
                @(negedge clk);
            end
            buildWord(w, mis);
            instrIn = w;
            misalignIn = mis;
            inValid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                outReady = ($random(seed) & 3) != 0;
                @(posedge clk);
                accepted = inReady;
                @(negedge clk);
            end
        end
        inValid = 1'b0;
        outReady = 1'b1;
        while (outCount != inCount)
            @(negedge clk);
        assert (!outValid)
            else abortRun("outValid still high after the last expected output");
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: instrDecoder_assert.sv
`default_nettype none
`timescale 1ns/10ps

module instrDecoderAssert
    import decodePkg::*;
(
    input logic     clk,
    input logic     rstN,
    input logic     inReady,
    input logic     outValid,
    input logic     outReady,
    input ctrlWordT ctrlOut
);

    resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high while reset is asserted");

    // a stalled output must not change
    stallHold: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(ctrlOut))
        else $error("output changed while stalled");

    readyRule: assert property (@(posedge clk) disable iff (!rstN)
        inReady == (!outValid || outReady))
        else $error("inReady does not follow outValid and outReady");

endmodule

bind instrDecoder instrDecoderAssert uAssert (
    .clk      (clk),
    .rstN     (rstN),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .ctrlOut  (ctrlOut)
);

`default_nettype wire

// File: list.f
decodePkg.sv
aluOpDecode.sv
memBranchDecode.sv
systemDecode.sv
instrDecoder.sv
instrDecoder_assert.sv
instrDecoderTb.sv

// File: memBranchDecode.sv
`default_nettype none
`timescale 1ns/10ps

module memBranchDecode
    import decodePkg::*;
(
    input  instrWordU instr,
    output ctrlWordT  ctrl,
    output logic      claim
);

    logic illegalOp;

    always_comb begin
        ctrl = '0;
        claim = 1'b0;
        illegalOp = 1'b0;
        case (instr.r.opcode)
            opLoad: begin
                claim = 1'b1;
                ctrl.immSel = immI;
                ctrl.bSel = 1'b1;
                ctrl.aluOp = aluAdd;
                ctrl.regWrite = 1'b1;
                ctrl.rd = instr.i.rd;
                ctrl.rs1En = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memUnsigned = instr.i.funct3[2];
                case (instr.i.funct3)
                    f3Byte, f3ByteU: ctrl.memSize = msize1;
                    f3Half, f3HalfU: ctrl.memSize = msize2;
                    f3Word, f3WordU: ctrl.memSize = msize4;
                    f3Dword: ctrl.memSize = msize8;
                    default: illegalOp = 1'b1;
                endcase
            end
            opStore: begin
                claim = 1'b1;
                ctrl.immSel = immS;
                ctrl.bSel = 1'b1;
                ctrl.aluOp = aluAdd;
                ctrl.rs1En = 1'b1;
                ctrl.rs2En = 1'b1;
                ctrl.memWrite = 1'b1;
                case (instr.r.funct3)
                    f3Byte: ctrl.memSize = msize1;
                    f3Half: ctrl.memSize = msize2;
                    f3Word: ctrl.memSize = msize4;
                    f3Dword: ctrl.memSize = msize8;
                    default: illegalOp = 1'b1;
                endcase
            end
            opBranch: begin
                claim = 1'b1;
                ctrl.immSel = immB;
                ctrl.aSel = 1'b1;
                ctrl.bSel = 1'b1;
                ctrl.rs1En = 1'b1;
                ctrl.rs2En = 1'b1;
                // sel picks the taken sense: equal or less-than
                case (instr.r.funct3)
                    f3Beq, f3Bne: begin
                        ctrl.eqEn = 1'b1;
                        ctrl.eqSel = (instr.r.funct3 == f3Beq);
                    end
                    f3Blt, f3Bge, f3Bltu, f3Bgeu: begin
                        ctrl.ltEn = 1'b1;
                        ctrl.ltSel = (instr.r.funct3 == f3Blt) || (instr.r.funct3 == f3Bltu);
                        ctrl.brUnsigned = (instr.r.funct3 == f3Bltu) || (instr.r.funct3 == f3Bgeu);
                    end
                    default: illegalOp = 1'b1;
                endcase
            end
            opJal, opJalr: begin
                claim = 1'b1;
                ctrl.immSel = (instr.r.opcode == opJalr) ? immI : immJ;
                ctrl.jalr = (instr.r.opcode == opJalr);
                ctrl.rs1En = (instr.r.opcode == opJalr);
                ctrl.aSel = 1'b1;
                ctrl.aluOp = aluNextPc;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel = 1'b1;
                ctrl.rd = instr.r.rd;
            end
            default: claim = 1'b0;
        endcase
        ctrl.exc.illegal = illegalOp;
        ctrl.isSystem = illegalOp;
    end

endmodule

`default_nettype wire

// File: systemDecode.sv
`default_nettype none
`timescale 1ns/10ps

module systemDecode
    import decodePkg::*;
(
    input  instrWordU instr,
    output ctrlWordT  ctrl,
    output logic      claim
);

    logic [24:0] funct25;

    assign funct25 = {instr.i.imm, instr.i.rs1, instr.i.funct3, instr.i.rd};

    always_comb begin
        ctrl = '0;
        claim = (instr.i.opcode == opSystem);
        if (claim) begin
            ctrl.isSystem = 1'b1;
            ctrl.csrAddr = instr.i.imm;
            case (instr.i.funct3)
                f3Priv: begin
                    ctrl.exc.ecall = (funct25 == f25Ecall);
                    ctrl.exc.mret = (funct25 == f25Mret);
                    ctrl.exc.illegal = (funct25 != f25Ecall) && (funct25 != f25Mret);
                end
                f3Csrrw, f3Csrrs, f3Csrrc: begin
                    ctrl.csrRs1 = 1'b1;
                    ctrl.rs1En = 1'b1;
                end
                f3Csrrwi, f3Csrrsi, f3Csrrci: begin
                    ctrl.csrImm = 1'b1;
                    ctrl.immSel = immCsr;
                    ctrl.bSel = 1'b1;
                end
                default: ctrl.exc.illegal = 1'b1;
            endcase
            case (instr.i.funct3)
                f3Csrrw: ctrl.aluOp = aluA;
                f3Csrrwi: ctrl.aluOp = aluB;
                f3Csrrs, f3Csrrsi: ctrl.aluOp = aluOr;
                f3Csrrc: ctrl.aluOp = aluRevAnd;
                f3Csrrci: ctrl.aluOp = aluAndRev;
                default: ctrl.aluOp = aluAdd;
            endcase
            // old csr value goes to rd
            if (ctrl.csrRs1 || ctrl.csrImm) begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel = 1'b1;
                ctrl.rd = instr.i.rd;
            end
        end
    end

endmodule

`default_nettype wire
